//--- dv/frontend_asserts.sv
// Bound assertions for the instruction front end
// Dispatch hold under stall, idle outputs after reset, one fetch in flight per warp

`include "bgpu_params.svh"

module frontend_asserts import bgpu_pkg::*; (
    input logic       clk_i,
    input logic       reset_i,
    input logic       start_i,
    input logic       fetch_valid_i,
    input fetch_req_t fetch_req_i,
    input logic       mem_ready_i,
    input logic       ic_valid_i,
    input logic       decoded_i,
    input wid_t       decoded_warp_id_i,
    input logic       disp_valid_i,
    input dec_inst_t  disp_inst_i,
    input logic       disp_ready_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Warps with a fetch taken and no decoded pulse yet
    logic [`NUM_WARPS-1:0] busy_q;

    always_ff @(posedge clk_i) begin
        if (reset_i || start_i) begin
            busy_q <= '0;
        end else begin
            if (fetch_valid_i && mem_ready_i) begin
                busy_q[fetch_req_i.warp_id] <= 1'b1;
            end
            if (decoded_i) begin
                busy_q[decoded_warp_id_i] <= 1'b0;
            end
        end
    end

    a_disp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        disp_valid_i && !disp_ready_i |=> disp_valid_i && $stable(disp_inst_i))
        else $error("dispatch output changed while stalled");

    a_reset_idle: assert property (@(posedge clk_i)
        reset_i |=> !fetch_valid_i && !ic_valid_i && !disp_valid_i && !decoded_i)
        else $error("handshake valid in the cycle after reset");

    a_one_in_flight: assert property (@(posedge clk_i) disable iff (reset_i)
        fetch_valid_i |-> !busy_q[fetch_req_i.warp_id])
        else $error("fetch selected warp %0d while it is in flight", fetch_req_i.warp_id);

endmodule : frontend_asserts

bind frontend_top frontend_asserts i_frontend_asserts (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .start_i           (start_i),
    .fetch_valid_i     (fetch_valid),
    .fetch_req_i       (fetch_req),
    .mem_ready_i       (mem_ready),
    .ic_valid_i        (ic_valid),
    .decoded_i         (decoded),
    .decoded_warp_id_i (decoded_warp_id),
    .disp_valid_i      (disp_valid_o),
    .disp_inst_i       (disp_inst_o),
    .disp_ready_i      (disp_ready_i)
);

//--- dv/frontend_tb.sv
// Testbench for the instruction front end
// Loads a program per warp, applies random back-pressure and checks every dispatch

`include "bgpu_params.svh"

module frontend_tb import bgpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        wid_t       warp;
        pc_t        pc;
        enc_inst_t  enc;
        logic [1:0] ops;
        logic       branch;
        logic       disp;
    } entry_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      prog_we;
    pc_t       prog_addr;
    enc_inst_t prog_data;
    logic      start;
    logic      disp_valid;
    dec_inst_t disp_inst;
    logic      disp_ready;
    logic      done;

    entry_t entries [$];
    entry_t exp_q [$];
    int     entry_at [1 << `PC_WIDTH];
    pc_t    fill_pc [`NUM_WARPS];
    int     pending [`NUM_WARPS];
    int     checked [`NUM_WARPS];
    int     warp_errs [`NUM_WARPS];
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    int     limit = 0;
    int     quiet_errs;
    bit     checking = 1'b0;

    frontend_top i_frontend_top (
        .clk_i        (clk),
        .reset_i      (reset),
        .prog_we_i    (prog_we),
        .prog_addr_i  (prog_addr),
        .prog_data_i  (prog_data),
        .start_i      (start),
        .disp_valid_o (disp_valid),
        .disp_inst_o  (disp_inst),
        .disp_ready_i (disp_ready),
        .done_o       (done)
    );

    always #5 clk = ~clk;

    task automatic store_entry(input wid_t w, input enc_inst_t word, input logic [1:0] ops,
                               input logic br, input logic disp);
        entry_t e;
        e.warp   = w;
        e.pc     = fill_pc[w];
        e.enc    = word;
        e.ops    = ops;
        e.branch = br;
        e.disp   = disp;
        entry_at[fill_pc[w]] = entries.size();
        entries.push_back(e);
        fill_pc[w] = fill_pc[w] + pc_t'(1);
    endtask

    // Register fields differ per entry so that a swapped instruction shows up
    task automatic add_entry(input wid_t w, input logic [7:0] opcode, input logic [1:0] ops,
                             input logic br, input logic disp);
        int n;
        n = entries.size();
        store_entry(w, {opcode, 8'(16 + n), 8'(32 + n), 8'(48 + n)}, ops, br, disp);
    endtask

    task automatic add_jump(input wid_t w, input logic [15:0] offset);
        store_entry(w, {8'h31, 8'h00, offset}, 2'b00, 1'b0, 1'b0);
    endtask

    task automatic build_table();
        // Warp 0 walks through every IU subtype
        add_entry(2'd0, 8'h00, 2'b11, 1'b0, 1'b1);
        add_entry(2'd0, 8'h01, 2'b11, 1'b0, 1'b1);
        add_entry(2'd0, 8'h02, 2'b11, 1'b0, 1'b1);
        add_entry(2'd0, 8'h03, 2'b11, 1'b0, 1'b1);
        add_entry(2'd0, 8'h04, 2'b11, 1'b0, 1'b1);
        add_entry(2'd0, 8'h05, 2'b11, 1'b0, 1'b1);
        add_entry(2'd0, 8'h06, 2'b10, 1'b0, 1'b1);
        add_entry(2'd0, 8'h07, 2'b10, 1'b0, 1'b1);
        add_entry(2'd0, 8'h08, 2'b10, 1'b0, 1'b1);
        add_entry(2'd0, 8'hFF, 2'b00, 1'b0, 1'b0);
        // Warp 1 covers FPU and LSU
        add_entry(2'd1, 8'h10, 2'b11, 1'b0, 1'b1);
        add_entry(2'd1, 8'h11, 2'b11, 1'b0, 1'b1);
        add_entry(2'd1, 8'h12, 2'b01, 1'b0, 1'b1);
        add_entry(2'd1, 8'h13, 2'b01, 1'b0, 1'b1);
        add_entry(2'd1, 8'h20, 2'b10, 1'b0, 1'b1);
        add_entry(2'd1, 8'h21, 2'b11, 1'b0, 1'b1);
        add_entry(2'd1, 8'hFF, 2'b00, 1'b0, 1'b0);
        // Warp 2 jumps forward over 130..131 and later back to them
        add_entry(2'd2, 8'h30, 2'b10, 1'b1, 1'b1);
        add_jump(2'd2, 16'h0002);
        add_entry(2'd2, 8'h00, 2'b11, 1'b0, 1'b1);
        add_entry(2'd2, 8'hFF, 2'b00, 1'b0, 1'b0);
        add_entry(2'd2, 8'h32, 2'b00, 1'b0, 1'b0);
        add_entry(2'd2, 8'h01, 2'b11, 1'b0, 1'b1);
        add_jump(2'd2, 16'hFFFB);
        // Warp 3 mixes units, sync and a zero-offset jump
        add_entry(2'd3, 8'h32, 2'b00, 1'b0, 1'b0);
        add_entry(2'd3, 8'h04, 2'b11, 1'b0, 1'b1);
        add_entry(2'd3, 8'h30, 2'b10, 1'b1, 1'b1);
        add_entry(2'd3, 8'h11, 2'b11, 1'b0, 1'b1);
        add_entry(2'd3, 8'h21, 2'b11, 1'b0, 1'b1);
        add_jump(2'd3, 16'h0000);
        add_entry(2'd3, 8'h06, 2'b10, 1'b0, 1'b1);
        add_entry(2'd3, 8'hFF, 2'b00, 1'b0, 1'b0);
    endtask

    // Follows one warp from its start PC until stop
    task automatic build_expected(input wid_t w);
        pc_t    pc;
        entry_t e;
        pc = pc_t'(int'(w) * `WARP_PC_STRIDE);
        for (int step = 0; step < 64; step++) begin
            if (entry_at[pc] < 0) begin
                $display("warp %0d program walk reached pc %0h with no instruction", w, pc);
                errors++;
                break;
            end
            e = entries[entry_at[pc]];
            if (e.disp) begin
                exp_q.push_back(e);
                pending[w]++;
            end
            if (e.enc[31:24] == `STOP_OPCODE) begin
                break;
            end
            if (e.enc[31:24] == 8'h31) begin
                pc = pc + e.enc[7:0] + pc_t'(1);
            end else begin
                pc = pc + pc_t'(1);
            end
        end
    endtask

    task automatic note_error(input wid_t w);
        errors++;
        warp_errs[w]++;
    endtask

    task automatic check_dispatch(input dec_inst_t d);
        int         idx;
        entry_t     e;
        wid_t       w;
        logic [7:0] opc;
        w   = d.warp_id;
        opc = d.inst;
        idx = -1;
        checks++;
        foreach (exp_q[i]) begin
            if (idx < 0 && exp_q[i].warp == w) begin
                idx = i;
            end
        end
        if (opc == 8'hFF || opc == 8'h31 || opc == 8'h32) begin
            $display("error at %0t: control opcode %h of warp %0d reached dispatch",
                     $time, opc, w);
            note_error(w);
        end
        if (idx < 0) begin
            $display("error at %0t: unexpected dispatch of warp %0d at pc %0h", $time, w, d.pc);
            note_error(w);
            return;
        end
        e = exp_q[idx];
        exp_q.delete(idx);
        pending[w]--;
        checked[w]++;
        if (d.pc !== e.pc || opc !== e.enc[31:24] || d.dst !== e.enc[23:16]
            || d.operands !== e.enc[15:0]) begin
            $display("error at %0t: warp %0d expected pc %0h word %h, got pc %0h op %h dst %h",
                     $time, w, e.pc, e.enc, d.pc, opc, d.dst);
            note_error(w);
        end
        if (d.operands_required !== e.ops) begin
            $display("error at %0t: warp %0d pc %0h operands_required %b, expected %b",
                     $time, w, d.pc, d.operands_required, e.ops);
            note_error(w);
        end
        if (d.branch !== e.branch) begin
            $display("error at %0t: warp %0d pc %0h branch %b, expected %b",
                     $time, w, d.pc, d.branch, e.branch);
            note_error(w);
        end
        if (pending[w] == 0) begin
            $display("warp %0d stream: %0d dispatches, %0d errors", w, checked[w], warp_errs[w]);
        end
    endtask

    // Outputs settle before the falling edge and transfer at the next rising edge
    always @(negedge clk) begin
        if (checking && disp_valid && disp_ready) begin
            check_dispatch(disp_inst);
        end
    end

    always @(posedge clk) begin
        if (checking) begin
            cycles++;
            if (cycles > limit) begin
                $display("timeout: dispatch streams or done did not finish in %0d cycles", limit);
                $display("Errors found");
                $finish;
            end
        end
    end

    initial begin
        reset      = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        start      = 1'b0;
        disp_ready = 1'b0;
        void'($urandom(32'h89bf));
        foreach (entry_at[a]) begin
            entry_at[a] = -1;
        end
        for (int w = 0; w < `NUM_WARPS; w++) begin
            fill_pc[w]   = pc_t'(w * `WARP_PC_STRIDE);
            pending[w]   = 0;
            checked[w]   = 0;
            warp_errs[w] = 0;
        end
        build_table();
        limit = 20 * entries.size() + 200;

        repeat (4) @(posedge clk);
        reset    <= 1'b0;
        checking = 1'b1;

        foreach (entries[i]) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= entries[i].pc;
            prog_data <= entries[i].enc;
        end
        @(posedge clk);
        prog_we <= 1'b0;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            build_expected(wid_t'(w));
        end

        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (exp_q.size() != 0) begin
            disp_ready <= ($urandom % 4) != 0;
            @(posedge clk);
        end

        disp_ready <= 1'b1;
        while (!done) begin
            @(negedge clk);
        end
        quiet_errs = errors;
        repeat (20) begin
            @(negedge clk);
            if (disp_valid || !done) begin
                $display("error at %0t: activity after done, disp_valid %b done %b",
                         $time, disp_valid, done);
                errors++;
            end
        end
        $display("done test: %0s", errors == quiet_errs ? "ok" : "failed");

        $display("dispatches checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : frontend_tb

//--- hw/bgpu_params.svh
// Front-end constants for the SIMT compute unit
// Shared by the package and the RTL blocks that size arrays or loops

`ifndef BGPU_PARAMS_SVH
`define BGPU_PARAMS_SVH

// Number of warps handled by the fetcher
`define NUM_WARPS 4

// Word address width of the program memory
`define PC_WIDTH 8

// Register index width for destination and operands
`define REG_IDX_WIDTH 8

// Encoded instruction width
`define ENC_INST_WIDTH 32

// Warp w starts at PC w * WARP_PC_STRIDE
`define WARP_PC_STRIDE 64

// Opcode byte of the stop instruction
`define STOP_OPCODE 8'hFF

`endif

//--- hw/bgpu_pkg.sv
// Shared types of the instruction front end
// Widths, opcode encodings and the structs passed between blocks

`include "bgpu_params.svh"

package bgpu_pkg;

    typedef logic [$clog2(`NUM_WARPS)-1:0] wid_t;
    typedef logic [`PC_WIDTH-1:0]          pc_t;
    typedef logic [`REG_IDX_WIDTH-1:0]     reg_idx_t;
    typedef logic [`ENC_INST_WIDTH-1:0]    enc_inst_t;

    // Execution unit selector, upper nibble of the opcode
    typedef enum logic [3:0] {
        EU_IU  = 4'd0,
        EU_FPU = 4'd1,
        EU_LSU = 4'd2,
        EU_BRU = 4'd3
    } eu_e;

    typedef enum logic [3:0] {
        IU_ADD  = 4'd0,
        IU_SUB  = 4'd1,
        IU_AND  = 4'd2,
        IU_OR   = 4'd3,
        IU_XOR  = 4'd4,
        IU_SHL  = 4'd5,
        IU_ADDI = 4'd6,
        IU_SUBI = 4'd7,
        IU_SHLI = 4'd8
    } iu_op_e;

    typedef enum logic [3:0] {
        FPU_FADD      = 4'd0,
        FPU_FMUL      = 4'd1,
        FPU_INT_TO_FP = 4'd2,
        FPU_FP_TO_INT = 4'd3
    } fpu_op_e;

    typedef enum logic [3:0] {
        LSU_LOAD  = 4'd0,
        LSU_STORE = 4'd1
    } lsu_op_e;

    typedef enum logic [3:0] {
        BRU_BRNZ = 4'd0,
        BRU_JMP  = 4'd1,
        BRU_SYNC = 4'd2
    } bru_op_e;

    // Opcode byte, 8'hFF is stop
    typedef struct packed {
        eu_e        eu;
        logic [3:0] subtype;
    } inst_t;

    typedef struct packed {
        wid_t warp_id;
        pc_t  pc;
    } fetch_req_t;

    typedef struct packed {
        wid_t                warp_id;
        pc_t                 pc;
        inst_t               inst;
        reg_idx_t            dst;
        reg_idx_t [1:0]      operands;
        logic     [1:0]      operands_required;
        logic                branch;
    } dec_inst_t;

endpackage : bgpu_pkg

//--- hw/decoder.sv
// Instruction decoder
// Splits the encoding, finds register operands and reports the next PC to the fetcher

`include "bgpu_params.svh"

module decoder import bgpu_pkg::*; (
    // From program memory
    input  logic       ic_valid_i,
    input  fetch_req_t ic_req_i,
    input  enc_inst_t  ic_inst_i,
    output logic       dec_ready_o,

    // To dispatch buffer
    input  logic       disp_ready_i,
    output logic       dec_valid_o,
    output dec_inst_t  dec_inst_o,

    // To fetcher
    output logic       dec_decoded_o,
    output wid_t       dec_decoded_warp_id_o,
    output pc_t        dec_decoded_next_pc_o,
    output logic       dec_stop_warp_o
);

    inst_t      inst;
    iu_op_e     iu_op;
    fpu_op_e    fpu_op;
    lsu_op_e    lsu_op;
    bru_op_e    bru_op;
    logic       is_stop;
    logic       is_control;
    logic [1:0] ops_req;
    logic       branch;
    pc_t        next_pc;

    assign inst    = inst_t'(ic_inst_i[31:24]);
    assign iu_op   = iu_op_e'(inst.subtype);
    assign fpu_op  = fpu_op_e'(inst.subtype);
    assign lsu_op  = lsu_op_e'(inst.subtype);
    assign bru_op  = bru_op_e'(inst.subtype);
    assign is_stop = ic_inst_i[31:24] == `STOP_OPCODE;

    always_comb begin
        next_pc    = ic_req_i.pc + pc_t'(1);
        branch     = 1'b0;
        ops_req    = 2'b00;
        is_control = is_stop;

        if (!is_stop) begin
            case (inst.eu)
                EU_IU: begin
                    case (iu_op)
                        IU_ADD, IU_SUB, IU_AND, IU_OR, IU_XOR, IU_SHL: ops_req = 2'b11;
                        // Operand 0 carries the immediate
                        IU_ADDI, IU_SUBI, IU_SHLI: ops_req = 2'b10;
                        default: ops_req = 2'b00;
                    endcase
                end
                EU_FPU: begin
                    if (fpu_op inside {FPU_INT_TO_FP, FPU_FP_TO_INT}) begin
                        ops_req = 2'b01;
                    end else begin
                        ops_req = 2'b11;
                    end
                end
                EU_LSU: begin
                    // Operand 1 is the address, operand 0 the store data
                    ops_req[1] = 1'b1;
                    ops_req[0] = lsu_op == LSU_STORE;
                end
                EU_BRU: begin
                    case (bru_op)
                        BRU_BRNZ: begin
                            // Condition register in operand 1, not resolved here
                            ops_req = 2'b10;
                            branch  = 1'b1;
                        end
                        BRU_JMP: begin
                            // Low bits of the 16-bit signed offset are enough for the PC
                            next_pc    = ic_req_i.pc + pc_t'(ic_inst_i[15:0]) + pc_t'(1);
                            is_control = 1'b1;
                        end
                        BRU_SYNC: is_control = 1'b1;
                        default: ops_req = 2'b00;
                    endcase
                end
                default: ops_req = 2'b00;
            endcase
        end
    end

    assign dec_ready_o = disp_ready_i;
    assign dec_valid_o = ic_valid_i && !is_control;

    assign dec_inst_o = '{
        warp_id:           ic_req_i.warp_id,
        pc:                ic_req_i.pc,
        inst:              inst,
        dst:               ic_inst_i[23:16],
        operands:          ic_inst_i[15:0],
        operands_required: ops_req,
        branch:            branch
    };

    // Dispatch handshake or consumed control instruction
    assign dec_decoded_o         = (dec_valid_o || (ic_valid_i && is_control)) && disp_ready_i;
    assign dec_decoded_warp_id_o = ic_req_i.warp_id;
    assign dec_decoded_next_pc_o = next_pc;
    assign dec_stop_warp_o       = is_stop;

endmodule : decoder

//--- hw/dispatch_buffer.sv
// Dispatch buffer
// Two-entry FIFO of decoded instructions toward the execution side

module dispatch_buffer import bgpu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    input  logic      in_valid_i,
    input  dec_inst_t in_inst_i,
    output logic      in_ready_o,

    output logic      out_valid_o,
    output dec_inst_t out_inst_o,
    input  logic      out_ready_i,

    output logic      empty_o
);

    dec_inst_t  entry_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    // Ready only looks at the fill level, no path from out_ready_i
    assign in_ready_o  = count_q != 2'd2;
    assign out_valid_o = count_q != 2'd0;
    assign out_inst_o  = entry_q[rd_ptr_q];
    assign empty_o     = count_q == 2'd0;

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            entry_q[wr_ptr_q] <= in_inst_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule : dispatch_buffer

//--- hw/frontend_top.sv
// Instruction front end
// Fetcher, program memory, decoder and dispatch buffer in one chain

module frontend_top import bgpu_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    // Program load
    input  logic      prog_we_i,
    input  pc_t       prog_addr_i,
    input  enc_inst_t prog_data_i,

    input  logic      start_i,

    // Dispatch toward execution
    output logic      disp_valid_o,
    output dec_inst_t disp_inst_o,
    input  logic      disp_ready_i,

    output logic      done_o
);

    logic       fetch_valid;
    fetch_req_t fetch_req;
    logic       mem_ready;

    logic       ic_valid;
    fetch_req_t ic_req;
    enc_inst_t  ic_inst;
    logic       dec_ready;

    logic       dec_valid;
    dec_inst_t  dec_inst;
    logic       buf_ready;

    logic       decoded;
    wid_t       decoded_warp_id;
    pc_t        decoded_next_pc;
    logic       decoded_stop;

    logic       all_stopped;
    logic       buf_empty;

    warp_fetcher i_warp_fetcher (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .start_i           (start_i),
        .mem_ready_i       (mem_ready),
        .fetch_valid_o     (fetch_valid),
        .fetch_req_o       (fetch_req),
        .decoded_i         (decoded),
        .decoded_warp_id_i (decoded_warp_id),
        .decoded_next_pc_i (decoded_next_pc),
        .decoded_stop_i    (decoded_stop),
        .all_stopped_o     (all_stopped)
    );

    program_mem i_program_mem (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .we_i        (prog_we_i),
        .waddr_i     (prog_addr_i),
        .wdata_i     (prog_data_i),
        .req_valid_i (fetch_valid),
        .req_i       (fetch_req),
        .ready_o     (mem_ready),
        .valid_o     (ic_valid),
        .req_o       (ic_req),
        .inst_o      (ic_inst),
        .out_ready_i (dec_ready)
    );

    decoder i_decoder (
        .ic_valid_i            (ic_valid),
        .ic_req_i              (ic_req),
        .ic_inst_i             (ic_inst),
        .dec_ready_o           (dec_ready),
        .disp_ready_i          (buf_ready),
        .dec_valid_o           (dec_valid),
        .dec_inst_o            (dec_inst),
        .dec_decoded_o         (decoded),
        .dec_decoded_warp_id_o (decoded_warp_id),
        .dec_decoded_next_pc_o (decoded_next_pc),
        .dec_stop_warp_o       (decoded_stop)
    );

    dispatch_buffer i_dispatch_buffer (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (dec_valid),
        .in_inst_i   (dec_inst),
        .in_ready_o  (buf_ready),
        .out_valid_o (disp_valid_o),
        .out_inst_o  (disp_inst_o),
        .out_ready_i (disp_ready_i),
        .empty_o     (buf_empty)
    );

    assign done_o = all_stopped && buf_empty;

endmodule : frontend_top

//--- hw/program_mem.sv
// Program memory with a write port for loading
// Registered read into an output stage that holds under back-pressure

`include "bgpu_params.svh"

module program_mem import bgpu_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,

    // Load port
    input  logic       we_i,
    input  pc_t        waddr_i,
    input  enc_inst_t  wdata_i,

    // Fetch request
    input  logic       req_valid_i,
    input  fetch_req_t req_i,
    output logic       ready_o,

    // Instruction toward decoder
    output logic       valid_o,
    output fetch_req_t req_o,
    output enc_inst_t  inst_o,
    input  logic       out_ready_i
);

    enc_inst_t  mem_q [1 << `PC_WIDTH];
    logic       valid_q;
    fetch_req_t req_q;
    enc_inst_t  inst_q;
    logic       req_fire;

    // Output stage frees up when empty or drained this cycle
    assign ready_o  = !valid_q || out_ready_i;
    assign req_fire = req_valid_i && ready_o;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_q  <= req_i;
            inst_q <= mem_q[req_i.pc];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (req_fire) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    assign valid_o = valid_q;
    assign req_o   = req_q;
    assign inst_o  = inst_q;

endmodule : program_mem

//--- hw/warp_fetcher.sv
// Warp fetcher
// Keeps one PC per warp and issues fetches round-robin over ready warps

`include "bgpu_params.svh"

module warp_fetcher import bgpu_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       start_i,

    // To program memory
    input  logic       mem_ready_i,
    output logic       fetch_valid_o,
    output fetch_req_t fetch_req_o,

    // Feedback from decoder
    input  logic       decoded_i,
    input  wid_t       decoded_warp_id_i,
    input  pc_t        decoded_next_pc_i,
    input  logic       decoded_stop_i,

    output logic       all_stopped_o
);

    pc_t                    pc_q [`NUM_WARPS];
    logic [`NUM_WARPS-1:0]  running_q;
    logic [`NUM_WARPS-1:0]  in_flight_q;
    logic [`NUM_WARPS-1:0]  selectable;
    wid_t                   last_grant_q;
    logic                   started_q;

    logic                   grant_valid;
    wid_t                   grant_id;
    wid_t                   cand_id;
    logic                   fetch_fire;

    // A warp may only have one instruction between fetch and decode
    assign selectable = running_q & ~in_flight_q;

    // Search starts one past the last granted warp
    always_comb begin
        grant_valid = 1'b0;
        grant_id    = '0;
        cand_id     = '0;
        for (int i = 1; i <= `NUM_WARPS; i++) begin
            cand_id = wid_t'((int'(last_grant_q) + i) % `NUM_WARPS);
            if (!grant_valid && selectable[cand_id]) begin
                grant_valid = 1'b1;
                grant_id    = cand_id;
            end
        end
    end

    assign fetch_valid_o = grant_valid;
    assign fetch_req_o   = '{warp_id: grant_id, pc: pc_q[grant_id]};
    assign fetch_fire    = fetch_valid_o && mem_ready_i;

    // Done only counts once a run has been started
    assign all_stopped_o = started_q && (running_q == '0);

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            for (int w = 0; w < `NUM_WARPS; w++) begin
                pc_q[w] <= pc_t'(w * `WARP_PC_STRIDE);
            end
        end else if (decoded_i) begin
            pc_q[decoded_warp_id_i] <= decoded_next_pc_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            running_q    <= '0;
            in_flight_q  <= '0;
            last_grant_q <= wid_t'(`NUM_WARPS - 1);
            started_q    <= 1'b0;
        end else if (start_i) begin
            running_q    <= '1;
            in_flight_q  <= '0;
            last_grant_q <= wid_t'(`NUM_WARPS - 1);
            started_q    <= 1'b1;
        end else begin
            if (fetch_fire) begin
                in_flight_q[grant_id] <= 1'b1;
                last_grant_q          <= grant_id;
            end
            // Decoded warp is in flight, so it never matches grant_id
            if (decoded_i) begin
                in_flight_q[decoded_warp_id_i] <= 1'b0;
                if (decoded_stop_i) begin
                    running_q[decoded_warp_id_i] <= 1'b0;
                end
            end
        end
    end

endmodule : warp_fetcher

//--- run_sim.sh
#!/bin/sh
# Build the front end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f sources.f --top-module frontend_tb -o frontend_sim

output=$(./obj_dir/frontend_sim || true)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

//--- sources.f
+incdir+hw
hw/bgpu_pkg.sv
hw/warp_fetcher.sv
hw/program_mem.sv
hw/decoder.sv
hw/dispatch_buffer.sv
hw/frontend_top.sv
dv/frontend_asserts.sv
dv/frontend_tb.sv
